// ==== verilog.f ====
+incdir+design
design/lsu_pkg.sv
design/lsu.sv
design/dcache_way.sv
design/dcache_ctrl.sv
design/wb_master.sv
design/lsu_top.sv
testbench/wb_mem_model.sv
testbench/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_lsu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '** FAIL **' "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

exit 0

// ==== testbench/tb_lsu.sv ====
module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 100;

    logic        clk;
    logic        rst;
    logic        req_valid;
    lsu_req_t    req;
    logic        req_ready;
    logic        resp_valid;
    logic [63:0] resp_data;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [28:0] wb_adr;
    logic [63:0] wb_dat_o;
    logic [7:0]  wb_sel;
    logic        wb_ack;
    logic [63:0] wb_dat_i;
    logic [1:0]  ack_delay;
    int unsigned bus_cycles;
    logic        last_we;
    logic [7:0]  last_sel;

    logic [7:0]  ref_mem [logic [31:0]];   // Byte-addressed reference
    logic [31:0] rng = 32'h3b56;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          failed_tests = 0;
    logic [63:0] got;
    int          latency;
    int          bus_used;

    lsu_top lsu_top_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_o),
        .wb_sel     (wb_sel),
        .wb_ack     (wb_ack),
        .wb_dat_i   (wb_dat_i)
    );

    wb_mem_model mem_i (
        .clk       (clk),
        .rst       (rst),
        .ack_delay (ack_delay),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_o),
        .wb_sel    (wb_sel),
        .wb_ack    (wb_ack),
        .wb_dat_o  (wb_dat_i),
        .cycles    (bus_cycles),
        .last_we   (last_we),
        .last_sel  (last_sel)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Response must be a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
        else begin
            $display("resp_valid stayed high for a second cycle at %0t", $time);
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst) (req_valid && req_ready) |=> !req_ready)
        else begin
            $display("req_ready stayed high after an accepted request at %0t", $time);
            errors++;
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw64(output logic [63:0] v);
        rng = xorshift32(rng);
        v[63:32] = rng;
        rng = xorshift32(rng);
        v[31:0] = rng;
    endtask

    function automatic int op_bytes(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_LWU, OP_SW: return 4;
            default:              return 8;
        endcase
    endfunction

    function automatic bit is_store(input mem_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    endfunction

    function automatic bit signed_load(input mem_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW};
    endfunction

    task automatic store_ref(input logic [31:0] addr, input int n, input logic [63:0] data);
        for (int i = 0; i < n; i++) begin
            ref_mem[addr + 32'(i)] = data[i*8 +: 8];
        end
    endtask

    // Little-endian gather, then extension by op
    function automatic logic [63:0] load_ref(input logic [31:0] addr, input mem_op_e op);
        logic [63:0] v;
        int          n;
        v = '0;
        n = op_bytes(op);
        for (int i = 0; i < n; i++) begin
            v[i*8 +: 8] = ref_mem[addr + 32'(i)];
        end
        if (signed_load(op) && v[n*8-1]) begin
            v = v | ~((64'd1 << (n * 8)) - 64'd1);
        end
        return v;
    endfunction

    function automatic logic [7:0] strobe_ref(input logic [31:0] addr, input int n);
        logic [7:0] s;
        s = 8'h00;
        for (int i = 0; i < n; i++) begin
            s[addr[2:0] + 3'(i)] = 1'b1;
        end
        return s;
    endfunction

    task automatic check_value(input string name, input logic [63:0] g, input logic [63:0] e);
        checks++;
        assert (g === e) else begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, g, e);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int g, input int e);
        checks++;
        assert (g == e) else begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, g, e);
            errors++;
        end
    endtask

    // One request, then wait for its response
    task automatic issue_request(input mem_op_e op, input logic [31:0] addr,
                                 input logic [63:0] wdata);
        int          waited;
        int          acc_cycle;
        int unsigned bus0;
        rng = xorshift32(rng);
        @(negedge clk);
        ack_delay  = rng[1:0];
        req_valid  = 1'b1;
        req.op     = op;
        req.addr   = addr;
        req.wdata  = wdata;
        waited = 0;
        while (!req_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (req_ready) else begin
            $display("Request to %h was never accepted at %0t", addr, $time);
            errors++;
        end
        bus0 = bus_cycles;
        @(negedge clk);
        req_valid = 1'b0;
        acc_cycle = cycle;
        waited = 0;
        while (!resp_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (resp_valid) else begin
            $display("No response for request to %h at %0t", addr, $time);
            errors++;
        end
        got      = resp_data;
        latency  = cycle - acc_cycle + 1;
        bus_used = int'(bus_cycles - bus0);
        if (is_store(op)) begin
            check_value("resp_data on store", got, 64'd0);
            store_ref(addr, op_bytes(op), wdata);
        end
    endtask

    task automatic load_and_check(input mem_op_e op, input logic [31:0] addr,
                                  input int exp_bus);
        issue_request(op, addr, 64'd0);
        check_value($sformatf("resp_data %s @%h", op.name(), addr), got, load_ref(addr, op));
        check_count($sformatf("bus cycles %s @%h", op.name(), addr), bus_used, exp_bus);
    endtask

    task automatic end_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("test %-22s ok", name);
        end else begin
            $display("test %-22s failed with %0d errors", name, errors - err_mark);
            failed_tests++;
        end
    endtask

    task automatic test_reset();
        check_value("req_ready", 64'(req_ready), 64'd1);
        check_value("wb_cyc", 64'(wb_cyc), 64'd0);
        check_value("resp_valid", 64'(resp_valid), 64'd0);
    endtask

    task automatic test_sizes();
        mem_op_e     st_ops [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
        mem_op_e     ld_ops [7] = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
        logic [31:0] base;
        logic [63:0] data;
        logic [2:0]  st_off;
        logic [2:0]  ld_off;
        base = 32'h0000_1040;
        for (int s = 0; s < 4; s++) begin
            draw64(data);
            issue_request(OP_SD, base, data);
            draw64(data);
            rng = xorshift32(rng);
            st_off = rng[2:0] & 3'(~(op_bytes(st_ops[s]) - 1));
            issue_request(st_ops[s], base | {29'd0, st_off}, data);
            for (int l = 0; l < 7; l++) begin
                ld_off = st_off & 3'(~(op_bytes(ld_ops[l]) - 1));
                issue_request(ld_ops[l], base | {29'd0, ld_off}, 64'd0);
                check_value($sformatf("resp_data %s", ld_ops[l].name()), got,
                            load_ref(base | {29'd0, ld_off}, ld_ops[l]));
            end
        end
    endtask

    task automatic test_hit();
        logic [63:0] data;
        draw64(data);
        issue_request(OP_SD, 32'h0000_3088, data);
        load_and_check(OP_LD, 32'h0000_3088, 1);    // Miss brings the line in
        load_and_check(OP_LD, 32'h0000_3088, 0);
        check_count("hit latency", latency, 2);
        load_and_check(OP_LWU, 32'h0000_308c, 0);
        check_count("hit latency", latency, 2);
    endtask

    task automatic test_store_hit();
        logic [63:0] data;
        draw64(data);
        issue_request(OP_SD, 32'h0000_40d0, data);
        load_and_check(OP_LD, 32'h0000_40d0, 1);
        draw64(data);
        issue_request(OP_SH, 32'h0000_40d2, data);
        check_count("bus cycles SH", bus_used, 1);
        check_value("wb_we", 64'(last_we), 64'd1);
        check_value("wb_sel", 64'(last_sel), 64'(strobe_ref(32'h0000_40d2, 2)));
        issue_request(OP_SB, 32'h0000_40d7, data);
        check_count("bus cycles SB", bus_used, 1);
        check_value("wb_sel", 64'(last_sel), 64'(strobe_ref(32'h0000_40d7, 1)));
        load_and_check(OP_LD, 32'h0000_40d0, 0);    // Merged line from the cache
    endtask

    task automatic test_device();
        logic [63:0] data;
        for (int r = 0; r < 2; r++) begin
            draw64(data);
            issue_request(OP_SD, 32'ha000_0040, data);
            check_count("bus cycles device SD", bus_used, 1);
            issue_request(OP_SW, 32'ha000_0044, data);
            check_count("bus cycles device SW", bus_used, 1);
            load_and_check(OP_LD, 32'ha000_0040, 1);
            load_and_check(OP_LD, 32'ha000_0040, 1);
            load_and_check(OP_LW, 32'ha000_0044, 1);
        end
    endtask

    task automatic test_evict();
        logic [63:0] data;
        logic [31:0] addr [5];
        for (int k = 0; k < 5; k++) begin
            addr[k] = 32'h0000_5028 + 32'(k) * 32'h80;   // Same set, new tag
            draw64(data);
            issue_request(OP_SD, addr[k], data);
        end
        for (int k = 0; k < 5; k++) begin
            load_and_check(OP_LD, addr[k], 1);
        end
        load_and_check(OP_LD, addr[0], 1);
        load_and_check(OP_LD, addr[4], 0);
    endtask

    initial begin
        int err_mark;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        ack_delay = 2'd0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        err_mark = errors;
        test_reset();
        end_test("reset state", err_mark);
        err_mark = errors;
        test_sizes();
        end_test("store and load sizes", err_mark);
        err_mark = errors;
        test_hit();
        end_test("load hit", err_mark);
        err_mark = errors;
        test_store_hit();
        end_test("store to cached line", err_mark);
        err_mark = errors;
        test_device();
        end_test("device region", err_mark);
        err_mark = errors;
        test_evict();
        end_test("round robin eviction", err_mark);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * 400) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 NUM_TESTS * 400);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== testbench/wb_mem_model.sv ====
module wb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  ack_delay,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [28:0] wb_adr,
    input  logic [63:0] wb_dat_i,
    input  logic [7:0]  wb_sel,
    output logic        wb_ack,
    output logic [63:0] wb_dat_o,
    output int unsigned cycles,
    output logic        last_we,
    output logic [7:0]  last_sel
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [63:0] mem [logic [28:0]];
    logic [1:0]  wait_cnt;
    logic [63:0] word;

    // Untouched words read back a pattern built from their address
    function automatic logic [63:0] fill_word(input logic [28:0] a);
        return {3'b101, a, 3'b010, ~a};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wait_cnt <= 2'd0;
            cycles   <= 0;
            last_we  <= 1'b0;
            last_sel <= 8'h00;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (wait_cnt == ack_delay) begin
                    word = mem.exists(wb_adr) ? mem[wb_adr] : fill_word(wb_adr);
                    if (wb_we) begin
                        for (int b = 0; b < 8; b++) begin
                            if (wb_sel[b]) begin
                                word[b*8 +: 8] = wb_dat_i[b*8 +: 8];
                            end
                        end
                        mem[wb_adr] = word;
                    end
                    wb_dat_o <= word;
                    wb_ack   <= 1'b1;
                    wait_cnt <= 2'd0;
                    cycles   <= cycles + 1;   // One per completed transfer
                    last_we  <= wb_we;
                    last_sel <= wb_sel;
                end else begin
                    wait_cnt <= wait_cnt + 2'd1;
                end
            end
        end
    end

endmodule

// ==== design/lsu_top.sv ====
`include "lsu_config.svh"

module lsu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  lsu_pkg::lsu_req_t req,
    output logic              req_ready,
    output logic              resp_valid,
    output logic [63:0]       resp_data,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [28:0]       wb_adr,
    output logic [63:0]       wb_dat_o,
    output logic [7:0]        wb_sel,
    input  logic              wb_ack,
    input  logic [63:0]       wb_dat_i
);
    import lsu_pkg::*;

    logic                       mem_valid;
    mem_req_t                   mem_req;
    logic                       mem_ready;
    logic                       mem_rvalid;
    logic [63:0]                mem_rdata;
    logic                       lookup_en;
    way_lookup_t                lookup;
    logic [`LSU_WAYS-1:0]       way_hit;
    logic [`LSU_WAYS-1:0][63:0] way_rdata;
    logic [`LSU_WAYS-1:0]       fill_en;
    way_fill_t                  fill;
    logic                       bus_start;
    wb_req_t                    bus_req;
    logic                       bus_done;
    logic [63:0]                bus_rdata;

    lsu lsu_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    dcache_ctrl dcache_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .lookup_en  (lookup_en),
        .lookup     (lookup),
        .way_hit    (way_hit),
        .way_rdata  (way_rdata),
        .fill_en    (fill_en),
        .fill       (fill),
        .bus_start  (bus_start),
        .bus_req    (bus_req),
        .bus_done   (bus_done),
        .bus_rdata  (bus_rdata)
    );

    for (genvar g = 0; g < `LSU_WAYS; g++) begin : gen_way
        dcache_way dcache_way_i (
            .clk       (clk),
            .rst       (rst),
            .lookup_en (lookup_en),
            .lookup    (lookup),
            .hit       (way_hit[g]),
            .rdata     (way_rdata[g]),
            .fill_en   (fill_en[g]),
            .fill      (fill)
        );
    end

    wb_master wb_master_i (
        .clk       (clk),
        .rst       (rst),
        .bus_start (bus_start),
        .bus_req   (bus_req),
        .bus_done  (bus_done),
        .bus_rdata (bus_rdata),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .wb_sel    (wb_sel),
        .wb_ack    (wb_ack),
        .wb_dat_i  (wb_dat_i)
    );

endmodule

// ==== design/wb_master.sv ====
module wb_master (
    input  logic             clk,
    input  logic             rst,
    input  logic             bus_start,
    input  lsu_pkg::wb_req_t bus_req,
    output logic             bus_done,
    output logic [63:0]      bus_rdata,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [28:0]      wb_adr,
    output logic [63:0]      wb_dat_o,
    output logic [7:0]       wb_sel,
    input  logic             wb_ack,
    input  logic [63:0]      wb_dat_i
);
    import lsu_pkg::*;

    wb_req_t req_q;
    logic    active;

    // Single transfer per cycle, so cyc and stb move together
    assign wb_cyc   = active;
    assign wb_stb   = active;
    assign wb_we    = req_q.we;
    assign wb_adr   = req_q.adr;
    assign wb_dat_o = req_q.dat;
    assign wb_sel   = req_q.sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            bus_done <= 1'b0;
        end else begin
            bus_done <= 1'b0;
            if (bus_start) begin
                active <= 1'b1;
            end else if (active && wb_ack) begin
                active   <= 1'b0;
                bus_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_start) begin
            req_q <= bus_req;
        end
        if (active && wb_ack) begin
            bus_rdata <= wb_dat_i;
        end
    end

    // Strobe and address held while the slave stalls
    assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)));

endmodule

// ==== design/dcache_ctrl.sv ====
`include "lsu_config.svh"

module dcache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           mem_valid,
    input  lsu_pkg::mem_req_t              mem_req,
    output logic                           mem_ready,
    output logic                           mem_rvalid,
    output logic [63:0]                    mem_rdata,
    output logic                           lookup_en,
    output lsu_pkg::way_lookup_t           lookup,
    input  logic [`LSU_WAYS-1:0]           way_hit,
    input  logic [`LSU_WAYS-1:0][63:0]     way_rdata,
    output logic [`LSU_WAYS-1:0]           fill_en,
    output lsu_pkg::way_fill_t             fill,
    output logic                           bus_start,
    output lsu_pkg::wb_req_t               bus_req,
    input  logic                           bus_done,
    input  logic [63:0]                    bus_rdata
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(`LSU_SETS);
    localparam int PTR_W = $clog2(`LSU_WAYS);

    ctrl_state_e      state;
    mem_req_t         req_q;
    logic [63:0]      rdata_q;
    logic [PTR_W-1:0] rr_ptr;
    logic [63:0]      hit_data;
    logic             any_hit;
    logic             refill;

    assign mem_ready  = state == S_IDLE;
    assign mem_rvalid = state == S_RESP;
    assign mem_rdata  = rdata_q;

    // Lookup straight from the incoming request
    assign lookup_en    = (state == S_IDLE) && mem_valid && !mem_req.device;
    assign lookup.index = mem_req.addr[IDX_W-1:0];
    assign lookup.tag   = mem_req.addr[28:IDX_W];

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < `LSU_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_data = hit_data | way_rdata[w];
            end
        end
    end

    assign any_hit = |way_hit;
    assign refill  = (state == S_BUS) && bus_done && !req_q.write && !req_q.device;

    always_comb begin
        fill_en = '0;
        if (state == S_LOOKUP && req_q.write) begin
            fill_en = way_hit;              // Write-through hit, no allocate on miss
        end else if (refill) begin
            fill_en[rr_ptr] = 1'b1;
        end
    end

    assign fill.index  = req_q.addr[IDX_W-1:0];
    assign fill.tag    = req_q.addr[28:IDX_W];
    assign fill.data   = req_q.write ? req_q.data : bus_rdata;
    assign fill.strb   = req_q.strb;
    assign fill.update = req_q.write;

    assign bus_req.we  = req_q.write;
    assign bus_req.adr = req_q.addr;
    assign bus_req.dat = req_q.data;
    assign bus_req.sel = req_q.strb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            bus_start <= 1'b0;
            rr_ptr    <= '0;
        end else begin
            bus_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (mem_valid) begin
                        if (mem_req.device) begin
                            bus_start <= 1'b1;
                            state     <= S_BUS;
                        end else begin
                            state <= S_LOOKUP;
                        end
                    end
                end
                S_LOOKUP: begin
                    if (any_hit && !req_q.write) begin
                        state <= S_RESP;
                    end else begin
                        bus_start <= 1'b1;  // Miss or store
                        state     <= S_BUS;
                    end
                end
                S_BUS: begin
                    if (bus_done) begin
                        state <= S_RESP;
                        if (refill) begin
                            rr_ptr <= rr_ptr + 1'b1;
                        end
                    end
                end
                S_RESP:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && mem_valid) begin
            req_q <= mem_req;
        end
        if (state == S_LOOKUP) begin
            rdata_q <= hit_data;
        end else if (state == S_BUS && bus_done) begin
            rdata_q <= bus_rdata;
        end
    end

    // A line lives in one way only
    assert property (@(posedge clk) disable iff (rst)
        (state == S_LOOKUP) |-> $onehot0(way_hit));

endmodule

// ==== design/dcache_way.sv ====
`include "lsu_config.svh"

module dcache_way (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lookup_en,
    input  lsu_pkg::way_lookup_t lookup,
    output logic                 hit,
    output logic [63:0]          rdata,
    input  logic                 fill_en,
    input  lsu_pkg::way_fill_t   fill
);

    logic [`LSU_SETS-1:0] valid;
    logic [24:0]          tag_mem  [`LSU_SETS];
    logic [63:0]          data_mem [`LSU_SETS];
    logic [63:0]          merged;

    // Store bytes over the old line
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            merged[b*8 +: 8] = fill.strb[b] ? fill.data[b*8 +: 8]
                                            : data_mem[fill.index][b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_en && !fill.update) begin
            valid[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[fill.index] <= fill.update ? merged : fill.data;
            if (!fill.update) begin
                tag_mem[fill.index] <= fill.tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (lookup_en) begin
            hit <= valid[lookup.index] && (tag_mem[lookup.index] == lookup.tag);
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rdata <= data_mem[lookup.index];
        end
    end

endmodule

// ==== design/lsu.sv ====
`include "lsu_config.svh"

module lsu (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  lsu_pkg::lsu_req_t   req,
    output logic                req_ready,
    output logic                resp_valid,
    output logic [63:0]         resp_data,
    output logic                mem_valid,
    output lsu_pkg::mem_req_t   mem_req,
    input  logic                mem_ready,
    input  logic                mem_rvalid,
    input  logic [63:0]         mem_rdata
);
    import lsu_pkg::*;

    logic        busy;
    mem_op_e     op_q;
    logic [2:0]  off_q;
    logic [2:0]  off;
    logic [7:0]  strb;
    logic        is_store;
    logic [63:0] rshift;

    assign off       = req.addr[2:0];
    assign is_store  = req.op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    assign req_ready = !busy && mem_ready;
    assign mem_valid = req_valid && !busy;

    always_comb begin
        case (req.op)
            OP_SB:   strb = 8'h01 << off;
            OP_SH:   strb = 8'h03 << off;
            OP_SW:   strb = 8'h0f << off;
            OP_SD:   strb = 8'hff;
            default: strb = 8'hff;      // Loads fetch the whole word
        endcase
    end

    always_comb begin
        mem_req.write  = is_store;
        mem_req.device = req.addr[31:28] == `LSU_DEV_NIBBLE;
        mem_req.addr   = req.addr[31:3];
        mem_req.data   = req.wdata << {off, 3'b000};
        mem_req.strb   = strb;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            op_q  <= OP_LD;
            off_q <= 3'd0;
        end else if (mem_valid && mem_ready) begin
            busy  <= 1'b1;
            op_q  <= req.op;
            off_q <= off;
        end else if (mem_rvalid) begin
            busy <= 1'b0;
        end
    end

    // Bring the addressed bytes down to bit 0
    assign rshift     = mem_rdata >> {off_q, 3'b000};
    assign resp_valid = mem_rvalid;

    always_comb begin
        case (op_q)
            OP_LB:   resp_data = {{56{rshift[7]}}, rshift[7:0]};
            OP_LH:   resp_data = {{48{rshift[15]}}, rshift[15:0]};
            OP_LW:   resp_data = {{32{rshift[31]}}, rshift[31:0]};
            OP_LD:   resp_data = rshift;
            OP_LBU:  resp_data = {56'd0, rshift[7:0]};
            OP_LHU:  resp_data = {48'd0, rshift[15:0]};
            OP_LWU:  resp_data = {32'd0, rshift[31:0]};
            default: resp_data = 64'd0;     // Stores answer zero
        endcase
    end

    // One request in flight, cache stays out of idle until its response
    assert property (@(posedge clk) disable iff (rst)
        busy |-> !mem_ready);

    // Cache never answers a request that was not issued
    assert property (@(posedge clk) disable iff (rst)
        mem_rvalid |-> busy);

endmodule

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

    // Bit 3 marks a store, bits 1:0 the access size
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LD  = 4'b0011,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_LWU = 4'b0110,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010,
        OP_SD  = 4'b1011
    } mem_op_e;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [63:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic        write;
        logic        device;
        logic [28:0] addr;      // Double-word address
        logic [63:0] data;
        logic [7:0]  strb;
    } mem_req_t;

    typedef struct packed {
        logic [3:0]  index;
        logic [24:0] tag;
    } way_lookup_t;

    typedef struct packed {
        logic [3:0]  index;
        logic [24:0] tag;
        logic [63:0] data;
        logic [7:0]  strb;
        logic        update;    // Byte merge on a write hit
    } way_fill_t;

    typedef struct packed {
        logic        we;
        logic [28:0] adr;
        logic [63:0] dat;
        logic [7:0]  sel;
    } wb_req_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_BUS,
        S_RESP
    } ctrl_state_e;

endpackage

// ==== design/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data cache geometry, one 8-byte word per line
`define LSU_WAYS 4
`define LSU_SETS 16

// Addresses with this top nibble go straight to the bus
`define LSU_DEV_NIBBLE 4'hA

`endif
